// File: bench/memory_access_stage_assertions.sv
// Concurrent checks on the cache strobes and the ma_ registers, bound into the stage top level
`timescale 1ns/1ps

module memory_access_stage_assertions
(
	input logic clk,
	input logic reset,
	input logic squash,
	input logic dcache_load,
	input logic dcache_store,
	input logic dcache_flush,
	input logic dcache_stbar,
	input logic dcache_dinvalidate,
	input logic dcache_iinvalidate,
	input logic dcache_req_sync,
	input logic ma_alignment_fault,
	input logic ma_enable_scalar_writeback,
	input logic ma_enable_vector_writeback
);

	logic any_strobe;

	assign any_strobe = dcache_load || dcache_store || dcache_flush || dcache_stbar
		|| dcache_dinvalidate || dcache_iinvalidate || dcache_req_sync;

	one_main_strobe: assert property (@(posedge clk) disable iff (reset)
		$onehot0({dcache_load, dcache_store, dcache_flush, dcache_stbar}))
		else $error("More than one of load, store, flush and stbar is high");

	squash_quiet: assert property (@(posedge clk) disable iff (reset) squash |-> !any_strobe)
		else $error("Cache strobe raised while squashed");

	// A faulting access never reached the cache
	fault_no_access: assert property (@(posedge clk) disable iff (reset)
		ma_alignment_fault |-> $past(!dcache_load && !dcache_store))
		else $error("Alignment fault follows an issued load or store");

	reset_enables_low: assert property (@(posedge clk)
		reset |-> !ma_enable_scalar_writeback && !ma_enable_vector_writeback)
		else $error("Writeback enables high during reset");

endmodule

bind memory_access_stage memory_access_stage_assertions u_assertions (.*);

// File: bench/memory_access_stage_tb.sv
// Table driven testbench for the memory access stage, run through the file list with Verilator
`timescale 1ns/1ps

module memory_access_stage_tb;

	localparam int NUM_TESTS = 18;
	localparam int CYCLE_LIMIT = 4 + 3 * NUM_TESTS + 20;
	localparam mem_stage_pkg::word_t SCALAR_VALUE = 32'hA1B2C3D4;	// Lane 15 store word
	// Strobe order is load, store, flush, stbar, dinvalidate, iinvalidate, sync
	localparam logic [6:0] S_NONE = 7'b0000000;
	localparam logic [6:0] S_LD = 7'b1000000;
	localparam logic [6:0] S_ST = 7'b0100000;
	localparam logic [6:0] S_FL = 7'b0010000;
	localparam logic [6:0] S_SB = 7'b0001000;
	localparam logic [6:0] S_DI = 7'b0000100;
	localparam logic [6:0] S_II = 7'b0000010;
	localparam logic [6:0] S_SY = 7'b0000001;

	logic clk = 1'b0;
	logic reset;
	logic squash;
	mem_stage_pkg::ex_bundle_t ex;
	mem_stage_pkg::vector_t ex_store_value;
	mem_stage_pkg::word_t ex_base_addr;
	logic dcache_load, dcache_store, dcache_flush, dcache_stbar;
	logic dcache_dinvalidate, dcache_iinvalidate, dcache_req_sync;
	mem_stage_pkg::line_addr_t dcache_addr;
	mem_stage_pkg::strand_t dcache_req_strand;
	mem_stage_pkg::store_mask_t dcache_store_mask;
	mem_stage_pkg::vector_t data_to_dcache;
	mem_stage_pkg::instr_t ma_instruction;
	mem_stage_pkg::strand_t ma_strand;
	mem_stage_pkg::word_t ma_pc;
	mem_stage_pkg::reg_idx_t ma_writeback_reg;
	logic ma_enable_scalar_writeback, ma_enable_vector_writeback;
	mem_stage_pkg::lane_mask_t ma_mask;
	mem_stage_pkg::vector_t ma_result;
	mem_stage_pkg::lane_idx_t ma_reg_lane_select, ma_cache_lane_select;
	logic ma_was_load;
	mem_stage_pkg::word_t ma_strided_offset;
	logic ma_alignment_fault;

	// Stimulus and expected values, one slot per test
	string t_name [NUM_TESTS];
	mem_stage_pkg::instr_t t_instr [NUM_TESTS];
	mem_stage_pkg::lane_mask_t t_mask [NUM_TESTS];
	mem_stage_pkg::word_t t_res_lo [NUM_TESTS];
	mem_stage_pkg::word_t t_ptr [NUM_TESTS];	// Scatter/gather pointer at the selected lane
	mem_stage_pkg::word_t t_base [NUM_TESTS];
	mem_stage_pkg::word_t t_off [NUM_TESTS];
	mem_stage_pkg::lane_idx_t t_rls [NUM_TESTS];
	logic t_squash [NUM_TESTS];
	logic [6:0] t_strobes [NUM_TESTS];
	mem_stage_pkg::line_addr_t t_addr [NUM_TESTS];
	mem_stage_pkg::lane_idx_t t_lane [NUM_TESTS];	// Cache lane of the effective address
	mem_stage_pkg::store_mask_t t_smask [NUM_TESTS];
	mem_stage_pkg::lane_idx_t t_chk [NUM_TESTS];	// Lane whose data word is checked
	int t_src [NUM_TESTS];	// Store lane feeding it, or -1 for a literal
	mem_stage_pkg::word_t t_data [NUM_TESTS];
	logic t_fault [NUM_TESTS];

	logic [31:0] rng_state = 32'haf90c7e6;
	int errors = 0;
	int cycles = 0;

	memory_access_stage DUT (.*);

	always #10 clk = ~clk;

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Test failures found");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	function automatic mem_stage_pkg::word_t swap_bytes(mem_stage_pkg::word_t w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	function automatic mem_stage_pkg::instr_t fmt_c(logic load, mem_stage_pkg::mem_op_t op);
		return {2'b10, load, op, 25'd0};
	endfunction

	function automatic mem_stage_pkg::instr_t fmt_d(mem_stage_pkg::cache_op_t op);
		return {4'b1110, op, 25'd0};
	endfunction

	// Result vector of test i with the pointer at the selected lane
	function automatic mem_stage_pkg::vector_t build_result(input int i);
		mem_stage_pkg::vector_t result;
		result = '0;
		result[(15 - t_rls[i])*32 +: 32] = t_ptr[i];
		result[31:0] = t_res_lo[i];
		return result;
	endfunction

	task automatic set_entry(input int i, input string name, input mem_stage_pkg::instr_t instr,
		input mem_stage_pkg::lane_mask_t mask, input mem_stage_pkg::word_t res_lo,
		input mem_stage_pkg::word_t ptr, input mem_stage_pkg::word_t base,
		input mem_stage_pkg::word_t off, input mem_stage_pkg::lane_idx_t rls, input logic sq,
		input logic [6:0] strobes, input mem_stage_pkg::line_addr_t addr,
		input mem_stage_pkg::lane_idx_t lane,
		input mem_stage_pkg::store_mask_t smask, input mem_stage_pkg::lane_idx_t chk,
		input int src, input mem_stage_pkg::word_t data, input logic fault);
		t_name[i] = name;
		t_instr[i] = instr;
		t_mask[i] = mask;
		t_res_lo[i] = res_lo;
		t_ptr[i] = ptr;
		t_base[i] = base;
		t_off[i] = off;
		t_rls[i] = rls;
		t_squash[i] = sq;
		t_strobes[i] = strobes;
		t_addr[i] = addr;
		t_lane[i] = lane;
		t_smask[i] = smask;
		t_chk[i] = chk;
		t_src[i] = src;
		t_data[i] = data;
		t_fault[i] = fault;
	endtask

	task automatic check_addr(input string test, input string what,
		input mem_stage_pkg::line_addr_t exp, input mem_stage_pkg::line_addr_t act);
		if (act !== exp)
		begin
			$display("[FAIL] %s %s expected %h actual %h", test, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_mask(input string test, input string what,
		input mem_stage_pkg::store_mask_t exp, input mem_stage_pkg::store_mask_t act);
		if (act !== exp)
		begin
			$display("[FAIL] %s %s expected %h actual %h", test, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_word(input string test, input string what,
		input mem_stage_pkg::word_t exp, input mem_stage_pkg::word_t act);
		if (act !== exp)
		begin
			$display("[FAIL] %s %s expected %h actual %h", test, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_bit(input string test, input string what, input logic exp,
		input logic act);
		if (act !== exp)
		begin
			$display("[FAIL] %s %s expected %b actual %b", test, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_instr(input string test, input string what,
		input mem_stage_pkg::instr_t exp, input mem_stage_pkg::instr_t act);
		if (act !== exp)
		begin
			$display("[FAIL] %s %s expected %h actual %h", test, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_strand(input string test, input string what,
		input mem_stage_pkg::strand_t exp, input mem_stage_pkg::strand_t act);
		if (act !== exp)
		begin
			$display("[FAIL] %s %s expected %h actual %h", test, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_reg_idx(input string test, input string what,
		input mem_stage_pkg::reg_idx_t exp, input mem_stage_pkg::reg_idx_t act);
		if (act !== exp)
		begin
			$display("[FAIL] %s %s expected %h actual %h", test, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_lane_mask(input string test, input string what,
		input mem_stage_pkg::lane_mask_t exp, input mem_stage_pkg::lane_mask_t act);
		if (act !== exp)
		begin
			$display("[FAIL] %s %s expected %h actual %h", test, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_lane_idx(input string test, input string what,
		input mem_stage_pkg::lane_idx_t exp, input mem_stage_pkg::lane_idx_t act);
		if (act !== exp)
		begin
			$display("[FAIL] %s %s expected %h actual %h", test, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_vector(input string test, input string what,
		input mem_stage_pkg::vector_t exp, input mem_stage_pkg::vector_t act);
		if (act !== exp)
		begin
			$display("[FAIL] %s %s expected %h actual %h", test, what, exp, act);
			errors++;
		end
	endtask

	// Registered fields of test i, one edge after it was applied
	task automatic check_registered(input int i);
		check_instr(t_name[i], "ma_instruction",
			t_squash[i] ? mem_stage_pkg::NOP_INSTR : t_instr[i], ma_instruction);
		check_bit(t_name[i], "ma_enable_scalar_writeback", !t_squash[i], ma_enable_scalar_writeback);
		check_bit(t_name[i], "ma_enable_vector_writeback", !t_squash[i], ma_enable_vector_writeback);
		check_bit(t_name[i], "ma_was_load", t_strobes[i][6], ma_was_load);
		check_bit(t_name[i], "ma_alignment_fault", t_fault[i] && !t_squash[i], ma_alignment_fault);
		check_word(t_name[i], "ma_pc", 32'h100 + 32'(4 * i), ma_pc);
		check_word(t_name[i], "ma_strided_offset", t_off[i], ma_strided_offset);
		check_strand(t_name[i], "ma_strand", mem_stage_pkg::strand_t'(i), ma_strand);
		check_reg_idx(t_name[i], "ma_writeback_reg", mem_stage_pkg::reg_idx_t'(i),
			ma_writeback_reg);
		check_lane_mask(t_name[i], "ma_mask", t_mask[i], ma_mask);
		check_vector(t_name[i], "ma_result", build_result(i), ma_result);
		check_lane_idx(t_name[i], "ma_reg_lane_select", t_rls[i], ma_reg_lane_select);
		check_lane_idx(t_name[i], "ma_cache_lane_select", t_lane[i], ma_cache_lane_select);
	endtask

	task automatic apply_and_check(input int i);
		mem_stage_pkg::word_t exp_data;
		for (int w = 0; w < mem_stage_pkg::NUM_LANES; w++)
			ex_store_value[w*32 +: 32] = xorshift();
		ex_store_value[31:0] = SCALAR_VALUE;
		ex.instruction = t_instr[i];
		ex.strand = mem_stage_pkg::strand_t'(i);
		ex.writeback_reg = mem_stage_pkg::reg_idx_t'(i);
		ex.enable_scalar_writeback = 1'b1;
		ex.enable_vector_writeback = 1'b1;
		ex.pc = 32'h100 + 32'(4 * i);
		ex.mask = t_mask[i];
		ex.result = build_result(i);
		ex.reg_lane_select = t_rls[i];
		ex.strided_offset = t_off[i];
		ex_base_addr = t_base[i];
		squash = t_squash[i];
		#1;
		if (t_src[i] >= 0)
			exp_data = swap_bytes(ex_store_value[(15 - t_src[i])*32 +: 32]);
		else
			exp_data = t_data[i];
		check_bit(t_name[i], "dcache_load", t_strobes[i][6], dcache_load);
		check_bit(t_name[i], "dcache_store", t_strobes[i][5], dcache_store);
		check_bit(t_name[i], "dcache_flush", t_strobes[i][4], dcache_flush);
		check_bit(t_name[i], "dcache_stbar", t_strobes[i][3], dcache_stbar);
		check_bit(t_name[i], "dcache_dinvalidate", t_strobes[i][2], dcache_dinvalidate);
		check_bit(t_name[i], "dcache_iinvalidate", t_strobes[i][1], dcache_iinvalidate);
		check_bit(t_name[i], "dcache_req_sync", t_strobes[i][0], dcache_req_sync);
		check_addr(t_name[i], "dcache_addr", t_addr[i], dcache_addr);
		check_strand(t_name[i], "dcache_req_strand", mem_stage_pkg::strand_t'(i),
			dcache_req_strand);
		check_mask(t_name[i], "dcache_store_mask", t_smask[i], dcache_store_mask);
		check_word(t_name[i], "lane data", exp_data, data_to_dcache[(15 - t_chk[i])*32 +: 32]);
	endtask

	initial
	begin
		reset = 1'b1;
		squash = 1'b0;
		ex = '0;
		ex_store_value = '0;
		ex_base_addr = '0;

		set_entry(0, "byte_st_off0", fmt_c(0, mem_stage_pkg::MEM_B), 16'h0001, 32'h1040, 0, 0, 0,
			0, 0, S_ST, 26'h41, 0, 64'h8000_0000_0000_0000, 0, -1, 32'hD400_0000, 0);
		set_entry(1, "byte_st_off3", fmt_c(0, mem_stage_pkg::MEM_B), 16'h0001, 32'h104B, 0, 0, 0,
			0, 0, S_ST, 26'h41, 2, 64'h0010_0000_0000_0000, 2, -1, 32'h0000_00D4, 0);
		set_entry(2, "half_st_hi", fmt_c(0, mem_stage_pkg::MEM_S), 16'h0001, 32'h1064, 0, 0, 0,
			0, 0, S_ST, 26'h41, 9, 64'h0000_0000_0C00_0000, 9, -1, 32'hD4C3_0000, 0);
		set_entry(3, "half_st_lo", fmt_c(0, mem_stage_pkg::MEM_S), 16'h0001, 32'h107E, 0, 0, 0,
			0, 0, S_ST, 26'h41, 15, 64'h0000_0000_0000_0003, 15, -1, 32'h0000_D4C3, 0);
		set_entry(4, "byte_ld", fmt_c(1, mem_stage_pkg::MEM_B), 16'h0001, 32'h2005, 0, 0, 0,
			0, 0, S_LD, 26'h80, 1, 64'h0400_0000_0000_0000, 1, -1, 32'h00D4_0000, 0);
		set_entry(5, "block_st", fmt_c(0, mem_stage_pkg::MEM_BLOCK), 16'hA005, 32'h3000, 0, 0, 0,
			0, 0, S_ST, 26'hC0, 0, 64'hF0F0_0000_0000_0F0F, 2, 2, 0, 0);
		set_entry(6, "block_misalign", fmt_c(0, mem_stage_pkg::MEM_BLOCK), 16'hFFFF, 32'h3010, 0,
			0, 0, 0, 0, S_NONE, 26'hC0, 4, 64'hFFFF_FFFF_FFFF_FFFF, 5, 5, 0, 1);
		set_entry(7, "strided_st", fmt_c(0, mem_stage_pkg::MEM_STRIDED), 16'h0008, 0, 0,
			32'h4000, 32'h28, 3, 0, S_ST, 26'h100, 10, 64'h0000_0000_00F0_0000, 10, 3, 0, 0);
		set_entry(8, "scgath_st", fmt_c(0, mem_stage_pkg::MEM_SCGATH), 16'h0020, 0, 32'h5034,
			0, 0, 5, 0, S_ST, 26'h140, 13, 64'h0000_0000_0000_0F00, 13, 5, 0, 0);
		set_entry(9, "scgath_off", fmt_c(0, mem_stage_pkg::MEM_SCGATH), 16'hFFDF, 0, 32'h5034,
			0, 0, 5, 0, S_NONE, 26'h140, 13, 64'h0, 13, 5, 0, 0);
		set_entry(10, "half_misalign", fmt_c(0, mem_stage_pkg::MEM_S), 16'h0001, 32'h1003, 0, 0,
			0, 0, 0, S_NONE, 26'h40, 0, 64'h3000_0000_0000_0000, 0, -1, 32'h0000_D4C3, 1);
		set_entry(11, "word_misalign_ld", fmt_c(1, mem_stage_pkg::MEM_L), 16'h0001, 32'h1006, 0,
			0, 0, 0, 0, S_NONE, 26'h40, 1, 64'h0F00_0000_0000_0000, 1, -1, 32'hD4C3_B2A1, 1);
		// Format D overlays a byte or half opcode, so the data lane is still positioned
		set_entry(12, "dflush", fmt_d(mem_stage_pkg::CACHE_DFLUSH), 16'h0000, 0, 0, 0, 0, 0, 0,
			S_FL, 26'h0, 0, 64'h0, 0, -1, 32'hD400_0000, 0);
		set_entry(13, "stbar", fmt_d(mem_stage_pkg::CACHE_STBAR), 16'h0000, 0, 0, 0, 0, 0, 0,
			S_SB, 26'h0, 0, 64'h0, 0, -1, 32'hD400_0000, 0);
		set_entry(14, "dinvalidate", fmt_d(mem_stage_pkg::CACHE_DINVALIDATE), 16'h0000, 0, 0, 0,
			0, 0, 0, S_DI, 26'h0, 0, 64'h0, 0, -1, 32'hD4C3_0000, 0);
		set_entry(15, "iinvalidate", fmt_d(mem_stage_pkg::CACHE_IINVALIDATE), 16'h0000, 0, 0, 0,
			0, 0, 0, S_II, 26'h0, 0, 64'h0, 0, -1, 32'hD4C3_0000, 0);
		set_entry(16, "squash_st", fmt_c(0, mem_stage_pkg::MEM_B), 16'h0001, 32'h1040, 0, 0, 0,
			0, 1, S_NONE, 26'h41, 0, 64'h8000_0000_0000_0000, 0, -1, 32'hD400_0000, 0);
		set_entry(17, "sync_st", fmt_c(0, mem_stage_pkg::MEM_SYNC), 16'h0001, 32'h6008, 0, 0,
			0, 0, 0, S_ST | S_SY, 26'h180, 2, 64'h00F0_0000_0000_0000, 2, -1, 32'hD4C3_B2A1, 0);

		repeat (2) @(negedge clk);
		check_instr("reset", "ma_instruction", '0, ma_instruction);
		check_strand("reset", "ma_strand", '0, ma_strand);
		check_word("reset", "ma_pc", '0, ma_pc);
		check_reg_idx("reset", "ma_writeback_reg", '0, ma_writeback_reg);
		check_bit("reset", "ma_enable_scalar_writeback", 1'b0, ma_enable_scalar_writeback);
		check_bit("reset", "ma_enable_vector_writeback", 1'b0, ma_enable_vector_writeback);
		check_lane_mask("reset", "ma_mask", '0, ma_mask);
		check_vector("reset", "ma_result", '0, ma_result);
		check_lane_idx("reset", "ma_reg_lane_select", '0, ma_reg_lane_select);
		check_lane_idx("reset", "ma_cache_lane_select", '0, ma_cache_lane_select);
		check_bit("reset", "ma_was_load", 1'b0, ma_was_load);
		check_word("reset", "ma_strided_offset", '0, ma_strided_offset);
		check_bit("reset", "ma_alignment_fault", 1'b0, ma_alignment_fault);
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		for (int i = 0; i < NUM_TESTS; i++)
		begin
			@(negedge clk);
			if (i > 0)
				check_registered(i - 1);
			apply_and_check(i);
		end
		@(negedge clk);
		check_registered(NUM_TESTS - 1);

		$display("Checks done with %0d errors", errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// File: memory_access_stage.f
src/mem_stage_pkg.sv
src/mem_op_decoder.sv
src/lane_store_formatter.sv
src/stage_register.sv
src/memory_access_stage.sv
bench/memory_access_stage_assertions.sv
bench/memory_access_stage_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the memory access stage testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
	--top-module memory_access_stage_tb \
	-f memory_access_stage.f \
	-o memory_access_stage_sim

./obj_dir/memory_access_stage_sim | tee sim.log

if grep -q "Test failures found" sim.log; then
	echo "Simulation reported failures"
	exit 1
fi
echo "Simulation finished without failures"

// File: src/lane_store_formatter.sv
// Per-lane store formatter producing one word's byte enables and big-endian positioned data
`timescale 1ns/1ps

module lane_store_formatter
#(
	parameter mem_stage_pkg::lane_idx_t LANE = '0
)
(
	input mem_stage_pkg::lane_cmd_t cmd,
	input mem_stage_pkg::word_t own_value,
	output mem_stage_pkg::lane_out_t lane
);

	mem_stage_pkg::word_t value;
	mem_stage_pkg::word_t swapped;
	mem_stage_pkg::word_t positioned;
	mem_stage_pkg::byte_en_t byte_en;
	logic lane_on;

	// Block vectors carry their own word, everything else shares one
	assign value = cmd.block ? own_value : cmd.scalar_value;
	assign swapped = {value[7:0], value[15:8], value[23:16], value[31:24]};

	assign lane_on = cmd.block ? cmd.lane_enable[LANE]
		: (cmd.cache_lane == LANE) && cmd.active;

	always_comb
	begin
		case (cmd.size)
			mem_stage_pkg::SIZE_BYTE:
			begin
				// Offset 0 lands in the top byte
				positioned = {24'd0, value[7:0]} << {~cmd.byte_offset, 3'b000};
				byte_en = 4'b1000 >> cmd.byte_offset;
			end
			mem_stage_pkg::SIZE_HALF:
			begin
				if (cmd.byte_offset[1])
				begin
					positioned = {16'd0, value[7:0], value[15:8]};
					byte_en = 4'b0011;
				end
				else
				begin
					positioned = {value[7:0], value[15:8], 16'd0};
					byte_en = 4'b1100;
				end
			end
			default:
			begin
				positioned = swapped;	// Word or vector lane
				byte_en = 4'b1111;
			end
		endcase
	end

	assign lane.data = positioned;
	assign lane.byte_en = byte_en & {4{lane_on && cmd.active}};

endmodule

// File: src/mem_op_decoder.sv
// Memory op decoder that classifies the instruction, checks alignment and drives the cache strobes
`timescale 1ns/1ps

module mem_op_decoder
(
	input mem_stage_pkg::ex_bundle_t ex,
	input mem_stage_pkg::vector_t ex_store_value,
	input mem_stage_pkg::word_t ex_base_addr,
	input logic squash,
	output logic dcache_load,
	output logic dcache_store,
	output logic dcache_flush,
	output logic dcache_stbar,
	output logic dcache_dinvalidate,
	output logic dcache_iinvalidate,
	output logic dcache_req_sync,
	output mem_stage_pkg::line_addr_t dcache_addr,
	output mem_stage_pkg::strand_t dcache_req_strand,
	output mem_stage_pkg::lane_cmd_t lane_cmd,
	output logic alignment_fault,
	output mem_stage_pkg::lane_idx_t cache_lane
);

	logic is_fmt_c;
	logic is_fmt_d;
	logic is_load;
	mem_stage_pkg::mem_op_t c_op;
	mem_stage_pkg::cache_op_t d_op;
	logic is_block;
	logic is_strided;
	logic is_scgath;
	mem_stage_pkg::access_size_t size;
	logic [5:0] align_mask;	// Low address bits that must be clear
	mem_stage_pkg::lane_idx_t word_pos;
	mem_stage_pkg::word_t strided_ptr;
	mem_stage_pkg::word_t sg_ptr;
	mem_stage_pkg::word_t sel_store_word;
	mem_stage_pkg::word_t eff_addr;
	mem_stage_pkg::lane_mask_t lane_one_hot;
	logic lane_active;
	logic misaligned;
	logic mem_access;

	assign is_fmt_c = ex.instruction[31:30] == 2'b10;
	assign is_fmt_d = ex.instruction[31:28] == 4'b1110;
	assign is_load = ex.instruction[29];
	assign c_op = ex.instruction[28:25];
	assign d_op = ex.instruction[27:25];

	// Access kind, size and alignment requirement
	always_comb
	begin
		is_block = 1'b0;
		is_strided = 1'b0;
		is_scgath = 1'b0;
		size = mem_stage_pkg::SIZE_WORD;
		align_mask = 6'b000011;
		case (c_op)
			mem_stage_pkg::MEM_B, mem_stage_pkg::MEM_BX:
			begin
				size = mem_stage_pkg::SIZE_BYTE;
				align_mask = 6'b000000;
			end
			mem_stage_pkg::MEM_S, mem_stage_pkg::MEM_SX:
			begin
				size = mem_stage_pkg::SIZE_HALF;
				align_mask = 6'b000001;
			end
			mem_stage_pkg::MEM_BLOCK, mem_stage_pkg::MEM_BLOCK_M, mem_stage_pkg::MEM_BLOCK_IM:
			begin
				is_block = 1'b1;
				size = mem_stage_pkg::SIZE_VECTOR;
				align_mask = 6'b111111;	// Whole line
			end
			mem_stage_pkg::MEM_STRIDED, mem_stage_pkg::MEM_STRIDED_M,
			mem_stage_pkg::MEM_STRIDED_IM:
				is_strided = 1'b1;
			mem_stage_pkg::MEM_SCGATH, mem_stage_pkg::MEM_SCGATH_M,
			mem_stage_pkg::MEM_SCGATH_IM:
				is_scgath = 1'b1;
			default: ;	// MEM_L, MEM_SYNC and MEM_CONTROL_REG are word scalars
		endcase
	end

	// Word of the selected lane, lane 0 sits in the top word
	assign word_pos = mem_stage_pkg::lane_idx_t'(mem_stage_pkg::NUM_LANES - 1) - ex.reg_lane_select;
	assign sg_ptr = ex.result[word_pos*32 +: 32];
	assign sel_store_word = ex_store_value[word_pos*32 +: 32];
	assign strided_ptr = ex_base_addr + ex.strided_offset;

	assign eff_addr = is_strided ? strided_ptr : (is_scgath ? sg_ptr : ex.result[31:0]);
	assign dcache_addr = eff_addr[31:6];
	assign cache_lane = eff_addr[5:2];
	assign misaligned = |(eff_addr[5:0] & align_mask);

	assign lane_active = is_block ? (ex.mask != '0) : ex.mask[ex.reg_lane_select];
	assign mem_access = is_fmt_c && !squash && lane_active;

	assign dcache_load = mem_access && !misaligned && is_load;
	assign dcache_store = mem_access && !misaligned && !is_load;
	assign dcache_req_sync = mem_access && !misaligned && c_op == mem_stage_pkg::MEM_SYNC;
	assign alignment_fault = mem_access && misaligned;
	assign dcache_req_strand = ex.strand;

	assign dcache_flush = is_fmt_d && !squash && d_op == mem_stage_pkg::CACHE_DFLUSH;
	assign dcache_stbar = is_fmt_d && !squash && d_op == mem_stage_pkg::CACHE_STBAR;
	assign dcache_dinvalidate = is_fmt_d && !squash && d_op == mem_stage_pkg::CACHE_DINVALIDATE;
	assign dcache_iinvalidate = is_fmt_d && !squash && d_op == mem_stage_pkg::CACHE_IINVALIDATE;

	assign lane_one_hot = mem_stage_pkg::lane_mask_t'(1) << cache_lane;

	always_comb
	begin
		lane_cmd.size = size;
		lane_cmd.byte_offset = eff_addr[1:0];
		lane_cmd.block = is_block;
		lane_cmd.cache_lane = cache_lane;
		lane_cmd.active = lane_active;
		if (is_block)
			lane_cmd.lane_enable = ex.mask;
		else if (is_strided || is_scgath)
			lane_cmd.lane_enable = lane_active ? lane_one_hot : '0;
		else
			lane_cmd.lane_enable = lane_one_hot;
		// Strided and scatter/gather store the selected lane
		if (is_strided || is_scgath)
			lane_cmd.scalar_value = sel_store_word;
		else
			lane_cmd.scalar_value = ex_store_value[31:0];
	end

endmodule

// File: src/mem_stage_pkg.sv
// Shared widths, types, opcode codes and structs for the memory access stage of the vector core
package mem_stage_pkg;

	localparam int NUM_LANES = 16;

	typedef logic [31:0] word_t;
	typedef logic [NUM_LANES*32-1:0] vector_t;	// Lane 15 in the low word
	typedef logic [NUM_LANES-1:0] lane_mask_t;	// Bit n belongs to lane n
	typedef logic [3:0] lane_idx_t;
	typedef logic [25:0] line_addr_t;	// Address bits 31:6
	typedef logic [63:0] store_mask_t;
	typedef logic [3:0] byte_en_t;
	typedef logic [1:0] strand_t;
	typedef logic [6:0] reg_idx_t;
	typedef logic [31:0] instr_t;
	typedef logic [3:0] mem_op_t;
	typedef logic [2:0] cache_op_t;
	typedef logic [1:0] access_size_t;

	// Format C memory opcodes
	localparam mem_op_t MEM_B = 4'd0;
	localparam mem_op_t MEM_BX = 4'd1;
	localparam mem_op_t MEM_S = 4'd2;
	localparam mem_op_t MEM_SX = 4'd3;
	localparam mem_op_t MEM_L = 4'd4;
	localparam mem_op_t MEM_SYNC = 4'd5;
	localparam mem_op_t MEM_CONTROL_REG = 4'd6;	// Reserved, handled as a word
	localparam mem_op_t MEM_BLOCK = 4'd7;
	localparam mem_op_t MEM_BLOCK_M = 4'd8;
	localparam mem_op_t MEM_BLOCK_IM = 4'd9;
	localparam mem_op_t MEM_STRIDED = 4'd10;
	localparam mem_op_t MEM_STRIDED_M = 4'd11;
	localparam mem_op_t MEM_STRIDED_IM = 4'd12;
	localparam mem_op_t MEM_SCGATH = 4'd13;
	localparam mem_op_t MEM_SCGATH_M = 4'd14;
	localparam mem_op_t MEM_SCGATH_IM = 4'd15;

	// Format D cache control opcodes
	localparam cache_op_t CACHE_DFLUSH = 3'd0;
	localparam cache_op_t CACHE_STBAR = 3'd1;
	localparam cache_op_t CACHE_DINVALIDATE = 3'd2;
	localparam cache_op_t CACHE_IINVALIDATE = 3'd3;

	localparam instr_t NOP_INSTR = 32'h0000_0000;

	localparam access_size_t SIZE_BYTE = 2'd0;
	localparam access_size_t SIZE_HALF = 2'd1;
	localparam access_size_t SIZE_WORD = 2'd2;
	localparam access_size_t SIZE_VECTOR = 2'd3;

	// Decoder to every lane formatter
	typedef struct packed {
		access_size_t size;
		logic [1:0] byte_offset;
		logic block;
		lane_mask_t lane_enable;
		lane_idx_t cache_lane;
		word_t scalar_value;
		logic active;
	} lane_cmd_t;

	// One lane's share of the line write
	typedef struct packed {
		byte_en_t byte_en;
		word_t data;
	} lane_out_t;

	typedef struct packed {
		instr_t instruction;
		strand_t strand;
		reg_idx_t writeback_reg;
		logic enable_scalar_writeback;
		logic enable_vector_writeback;
		word_t pc;
		lane_mask_t mask;
		vector_t result;
		lane_idx_t reg_lane_select;
		word_t strided_offset;
	} ex_bundle_t;

endpackage

// File: src/memory_access_stage.sv
// Memory access stage top level joining the decoder, the lane formatters and the stage register
`timescale 1ns/1ps

module memory_access_stage
(
	input logic clk,
	input logic reset,
	input logic squash,
	input mem_stage_pkg::ex_bundle_t ex,
	input mem_stage_pkg::vector_t ex_store_value,
	input mem_stage_pkg::word_t ex_base_addr,
	output logic dcache_load,
	output logic dcache_store,
	output logic dcache_flush,
	output logic dcache_stbar,
	output logic dcache_dinvalidate,
	output logic dcache_iinvalidate,
	output logic dcache_req_sync,
	output mem_stage_pkg::line_addr_t dcache_addr,
	output mem_stage_pkg::strand_t dcache_req_strand,
	output mem_stage_pkg::store_mask_t dcache_store_mask,
	output mem_stage_pkg::vector_t data_to_dcache,
	output mem_stage_pkg::instr_t ma_instruction,
	output mem_stage_pkg::strand_t ma_strand,
	output mem_stage_pkg::word_t ma_pc,
	output mem_stage_pkg::reg_idx_t ma_writeback_reg,
	output logic ma_enable_scalar_writeback,
	output logic ma_enable_vector_writeback,
	output mem_stage_pkg::lane_mask_t ma_mask,
	output mem_stage_pkg::vector_t ma_result,
	output mem_stage_pkg::lane_idx_t ma_reg_lane_select,
	output mem_stage_pkg::lane_idx_t ma_cache_lane_select,
	output logic ma_was_load,
	output mem_stage_pkg::word_t ma_strided_offset,
	output logic ma_alignment_fault
);

	mem_stage_pkg::lane_cmd_t lane_cmd;
	mem_stage_pkg::lane_out_t lane_outs [mem_stage_pkg::NUM_LANES];
	logic alignment_fault;
	mem_stage_pkg::lane_idx_t cache_lane;

	mem_op_decoder u_decoder (
		.ex(ex),
		.ex_store_value(ex_store_value),
		.ex_base_addr(ex_base_addr),
		.squash(squash),
		.dcache_load(dcache_load),
		.dcache_store(dcache_store),
		.dcache_flush(dcache_flush),
		.dcache_stbar(dcache_stbar),
		.dcache_dinvalidate(dcache_dinvalidate),
		.dcache_iinvalidate(dcache_iinvalidate),
		.dcache_req_sync(dcache_req_sync),
		.dcache_addr(dcache_addr),
		.dcache_req_strand(dcache_req_strand),
		.lane_cmd(lane_cmd),
		.alignment_fault(alignment_fault),
		.cache_lane(cache_lane)
	);

	genvar i;
	generate
		for (i = 0; i < mem_stage_pkg::NUM_LANES; i++)
		begin : g_lane
			lane_store_formatter #(
				.LANE(mem_stage_pkg::lane_idx_t'(i))
			) u_fmt (
				.cmd(lane_cmd),
				.own_value(ex_store_value[(mem_stage_pkg::NUM_LANES - 1 - i)*32 +: 32]),
				.lane(lane_outs[i])
			);
		end
	endgenerate

	stage_register u_stage_reg (
		.clk(clk),
		.reset(reset),
		.squash(squash),
		.ex(ex),
		.lanes(lane_outs),
		.dcache_load(dcache_load),
		.alignment_fault(alignment_fault),
		.cache_lane(cache_lane),
		.dcache_store_mask(dcache_store_mask),
		.data_to_dcache(data_to_dcache),
		.ma_instruction(ma_instruction),
		.ma_strand(ma_strand),
		.ma_pc(ma_pc),
		.ma_writeback_reg(ma_writeback_reg),
		.ma_enable_scalar_writeback(ma_enable_scalar_writeback),
		.ma_enable_vector_writeback(ma_enable_vector_writeback),
		.ma_mask(ma_mask),
		.ma_result(ma_result),
		.ma_reg_lane_select(ma_reg_lane_select),
		.ma_cache_lane_select(ma_cache_lane_select),
		.ma_was_load(ma_was_load),
		.ma_strided_offset(ma_strided_offset),
		.ma_alignment_fault(ma_alignment_fault)
	);

endmodule

// File: src/stage_register.sv
// Stage register that packs the lane writes for the cache and holds the writeback fields
`timescale 1ns/1ps

module stage_register
(
	input logic clk,
	input logic reset,
	input logic squash,
	input mem_stage_pkg::ex_bundle_t ex,
	input mem_stage_pkg::lane_out_t lanes [mem_stage_pkg::NUM_LANES],
	input logic dcache_load,
	input logic alignment_fault,
	input mem_stage_pkg::lane_idx_t cache_lane,
	output mem_stage_pkg::store_mask_t dcache_store_mask,
	output mem_stage_pkg::vector_t data_to_dcache,
	output mem_stage_pkg::instr_t ma_instruction,
	output mem_stage_pkg::strand_t ma_strand,
	output mem_stage_pkg::word_t ma_pc,
	output mem_stage_pkg::reg_idx_t ma_writeback_reg,
	output logic ma_enable_scalar_writeback,
	output logic ma_enable_vector_writeback,
	output mem_stage_pkg::lane_mask_t ma_mask,
	output mem_stage_pkg::vector_t ma_result,
	output mem_stage_pkg::lane_idx_t ma_reg_lane_select,
	output mem_stage_pkg::lane_idx_t ma_cache_lane_select,
	output logic ma_was_load,
	output mem_stage_pkg::word_t ma_strided_offset,
	output logic ma_alignment_fault
);

	// Lane 0 occupies the top word of the line
	genvar i;
	generate
		for (i = 0; i < mem_stage_pkg::NUM_LANES; i++)
		begin : g_pack
			localparam int POS = mem_stage_pkg::NUM_LANES - 1 - i;

			assign dcache_store_mask[POS*4 +: 4] = lanes[i].byte_en;
			assign data_to_dcache[POS*32 +: 32] = lanes[i].data;
		end
	endgenerate

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			ma_instruction <= '0;
			ma_strand <= '0;
			ma_pc <= '0;
			ma_writeback_reg <= '0;
			ma_enable_scalar_writeback <= 1'b0;
			ma_enable_vector_writeback <= 1'b0;
			ma_mask <= '0;
			ma_result <= '0;
			ma_reg_lane_select <= '0;
			ma_cache_lane_select <= '0;
			ma_was_load <= 1'b0;
			ma_strided_offset <= '0;
			ma_alignment_fault <= 1'b0;
		end
		else
		begin
			ma_strand <= ex.strand;
			ma_pc <= ex.pc;
			ma_writeback_reg <= ex.writeback_reg;
			ma_mask <= ex.mask;
			ma_result <= ex.result;
			ma_reg_lane_select <= ex.reg_lane_select;
			ma_cache_lane_select <= cache_lane;
			ma_was_load <= dcache_load;	// Already low under squash
			ma_strided_offset <= ex.strided_offset;
			if (squash)
			begin
				// Turn the slot into a bubble
				ma_instruction <= mem_stage_pkg::NOP_INSTR;
				ma_enable_scalar_writeback <= 1'b0;
				ma_enable_vector_writeback <= 1'b0;
				ma_alignment_fault <= 1'b0;
			end
			else
			begin
				ma_instruction <= ex.instruction;
				ma_enable_scalar_writeback <= ex.enable_scalar_writeback;
				ma_enable_vector_writeback <= ex.enable_vector_writeback;
				ma_alignment_fault <= alignment_fault;
			end
		end
	end

endmodule
